// File: files.f
src/rvv_pkg.sv
src/vrf_if.sv
src/insn_decoder.sv
src/vec_regfile.sv
src/vrf_write_arbiter.sv
src/vec_alu.sv
src/vec_lsu.sv
src/rvv_proc_main.sv
tests/rvv_proc_tb.sv

// File: Bender.yml
package:
  name: rvv_proc

sources:
  - src/rvv_pkg.sv
  - src/vrf_if.sv
  - src/insn_decoder.sv
  - src/vec_regfile.sv
  - src/vrf_write_arbiter.sv
  - src/vec_alu.sv
  - src/vec_lsu.sv
  - src/rvv_proc_main.sv
  - target: simulation
    files:
      - tests/rvv_proc_tb.sv

// File: tests/rvv_proc_tb.sv
`timescale 1ns/1ns

module rvv_proc_tb;

    localparam int VLEN    = 64;
    localparam int NUM_VEC = 32;
    // cycles any single wait may take
    localparam int TIMEOUT = 20;

    logic            clk;
    logic            rst;
    logic            insn_valid;
    logic [31:0]     insn;
    logic            mem_rvalid;
    logic [VLEN-1:0] mem_rdata;
    logic            mem_rd;
    logic            mem_we;
    logic [4:0]      mem_addr;
    logic [VLEN-1:0] mem_wdata;
    logic            busy;
    logic            illegal;

    // memory model state
    logic [VLEN-1:0] mem [32];
    int              rd_cnt;
    logic [4:0]      rd_word;
    int              next_delay;

    // expected register contents
    logic [VLEN-1:0] ref_regs [NUM_VEC];
    logic [31:0]     rng;
    bit              illegal_expected;
    int              value_errs;
    int              other_errs;

    rvv_proc_main #(.VLEN(VLEN), .NUM_VEC(NUM_VEC)) rvv_proc_main_i (
        .clk       (clk),
        .rst       (rst),
        .insn_valid(insn_valid),
        .insn      (insn),
        .mem_rvalid(mem_rvalid),
        .mem_rdata (mem_rdata),
        .mem_rd    (mem_rd),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .busy      (busy),
        .illegal   (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // only the stimulus process draws numbers, so the sequence is fixed
    function logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [31:0] opivv_insn(input logic [5:0] f6, input logic vm,
                                               input logic [4:0] vs2, input logic [4:0] vs1,
                                               input logic [4:0] vd);
        return {f6, vm, vs2, vs1, 3'b000, vd, 7'h57};
    endfunction

    // nf=0, mew=0, unmasked, e64
    function automatic logic [31:0] vmem_insn(input logic [6:0] opc, input logic [1:0] mop,
                                              input logic [4:0] rs1, input logic [4:0] vd);
        return {3'b000, 1'b0, mop, 1'b1, 5'd0, rs1, 3'd7, vd, opc};
    endfunction

    // 8-bit lanes, vs2 op vs1, mov copies vs1
    function automatic logic [VLEN-1:0] lane_result(input logic [5:0] f6,
                                                    input logic [VLEN-1:0] vs2,
                                                    input logic [VLEN-1:0] vs1);
        logic [VLEN-1:0] r;
        logic [7:0]      a;
        logic [7:0]      b;
        r = '0;
        for (int l = 0; l < VLEN / 8; l++) begin
            a = vs1[8*l +: 8];
            b = vs2[8*l +: 8];
            case (f6)
                6'h00:   r[8*l +: 8] = b + a;
                6'h02:   r[8*l +: 8] = b - a;
                6'h09:   r[8*l +: 8] = b & a;
                6'h0A:   r[8*l +: 8] = b | a;
                6'h0B:   r[8*l +: 8] = b ^ a;
                default: r[8*l +: 8] = a;
            endcase
        end
        return r;
    endfunction

    // memory: reads answered after next_delay cycles, writes applied
    always @(negedge clk) begin
        mem_rvalid = 1'b0;
        if (rd_cnt != 0) begin
            rd_cnt = rd_cnt - 1;
            if (rd_cnt == 0) begin
                mem_rvalid = 1'b1;
                mem_rdata  = mem[rd_word];
            end
        end
        if (mem_rd) begin
            rd_cnt  = next_delay;
            rd_word = mem_addr;
        end
        if (mem_we) begin
            mem[mem_addr] = mem_wdata;
        end
    end

    // busy covers request, memory wait and pending write
    a_busy_with_rd: assert property (@(posedge clk) disable iff (!rst) mem_rd |-> busy)
        else begin
            other_errs++;
            $display("%0t: load request without busy", $time);
        end
    a_busy_wait: assert property (@(posedge clk) disable iff (!rst) (rd_cnt != 0) |-> busy)
        else begin
            other_errs++;
            $display("%0t: busy dropped while load pending", $time);
        end
    a_busy_rvalid: assert property (@(posedge clk) disable iff (!rst)
        mem_rvalid |-> busy ##1 busy)
        else begin
            other_errs++;
            $display("%0t: busy dropped before load write", $time);
        end
    a_single_rd: assert property (@(posedge clk) disable iff (!rst) mem_rd |-> !$past(busy))
        else begin
            other_errs++;
            $display("%0t: second load request under busy", $time);
        end
    a_illegal_expected: assert property (@(posedge clk) disable iff (!rst)
        illegal |-> illegal_expected)
        else begin
            other_errs++;
            $display("%0t: illegal on a legal instruction", $time);
        end

    task automatic check_reset_outputs();
        assert (!mem_rd && !mem_we && !busy && !illegal)
            else begin
                other_errs++;
                $display("%0t: outputs not low around reset", $time);
            end
    endtask

    // called on a falling edge, returns on the next one
    task automatic issue_insn(input logic [31:0] w);
        insn_valid = 1'b1;
        insn       = w;
        @(negedge clk);
        insn_valid = 1'b0;
        insn       = '0;
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            other_errs++;
            $display("%0t: busy never fell after a load", $time);
        end
    endtask

    task automatic run_load(input logic [4:0] vd, input logic [4:0] word, input int delay);
        next_delay   = delay;
        ref_regs[vd] = mem[word];
        issue_insn(vmem_insn(7'h07, 2'b00, word, vd));
        wait_not_busy();
    endtask

    task automatic run_alu(input logic [5:0] f6, input logic [4:0] vd, input logic [4:0] vs2,
                           input logic [4:0] vs1, input int idle);
        ref_regs[vd] = lane_result(f6, ref_regs[vs2], ref_regs[vs1]);
        issue_insn(opivv_insn(f6, 1'b1, vs2, vs1, vd));
        repeat (idle) @(negedge clk);
    endtask

    task automatic run_store(input logic [4:0] vs3, input logic [4:0] word);
        int              n;
        logic [VLEN-1:0] exp_data;
        exp_data = ref_regs[vs3];
        issue_insn(vmem_insn(7'h27, 2'b00, word, vs3));
        n = 0;
        while (!mem_we && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!mem_we) begin
            other_errs++;
            $display("%0t: store of v%0d never produced a write strobe", $time, vs3);
        end else begin
            assert (mem_addr == word) else begin
                value_errs++;
                $display("FAILED %0t mem_addr expected %0d got %0d", $time, word, mem_addr);
            end
            assert (mem_wdata == exp_data) else begin
                value_errs++;
                $display("FAILED %0t mem_wdata expected %h got %h", $time, exp_data, mem_wdata);
            end
            @(negedge clk);
            assert (!mem_we)
                else begin
                    other_errs++;
                    $display("%0t: store strobe too long", $time);
                end
        end
    endtask

    // no strobe, one-cycle flag
    task automatic try_illegal(input logic [31:0] w, input string what);
        bit strobe;
        strobe           = 1'b0;
        illegal_expected = 1'b1;
        issue_insn(w);
        assert (illegal)
            else begin
                other_errs++;
                $display("%0t: %s not flagged illegal", $time, what);
            end
        repeat (4) begin
            strobe |= mem_rd || mem_we;
            @(negedge clk);
            assert (!illegal)
                else begin
                    other_errs++;
                    $display("%0t: %s held illegal", $time, what);
                end
        end
        assert (!strobe)
            else begin
                other_errs++;
                $display("%0t: %s reached memory", $time, what);
            end
        illegal_expected = 1'b0;
    endtask

    initial begin
        logic [5:0] ops [6];
        int         k;
        int         w1;
        int         w2;
        ops              = '{6'h00, 6'h02, 6'h09, 6'h0A, 6'h0B, 6'h17};
        rst              = 1'b0;
        insn_valid       = 1'b0;
        insn             = '0;
        mem_rvalid       = 1'b0;
        mem_rdata        = '0;
        rd_cnt           = 0;
        rd_word          = '0;
        next_delay       = 1;
        illegal_expected = 1'b0;
        value_errs       = 0;
        other_errs       = 0;
        rng              = 32'd5060;
        for (int i = 0; i < 32; i++) begin
            mem[i][63:32] = rand32();
            mem[i][31:0]  = rand32();
        end
        // lanes picked to wrap under add and sub
        mem[30] = 64'hff80_7f01_00ff_fe10;
        mem[31] = 64'h0180_8102_01ff_03f0;

        repeat (3) begin
            @(negedge clk);
            check_reset_outputs();
        end
        rst = 1'b1;
        @(negedge clk);
        check_reset_outputs();

        // load word k, store it back at another word
        k = int'(rand32() % 30);
        run_load(5'd1, 5'(k), int'(1 + rand32() % 6));
        run_store(5'd1, 5'((k + 9) % 30));

        // random operands first, then the wrapping pair
        for (int p = 0; p < 2; p++) begin
            w1 = (p == 0) ? int'(rand32() % 30) : 30;
            w2 = (p == 0) ? int'(rand32() % 30) : 31;
            run_load(5'd2, 5'(w1), int'(1 + rand32() % 6));
            run_load(5'd3, 5'(w2), int'(1 + rand32() % 6));
            for (int i = 0; i < 6; i++) begin
                run_alu(ops[i], 5'(4 + i), 5'd2, 5'd3, 2);
                run_store(5'(4 + i), 5'(16 + i));
            end
        end

        // alu writeback right ahead of the fastest load write
        run_alu(6'h00, 5'd12, 5'd2, 5'd3, 0);
        run_load(5'd13, 5'd7, 1);
        run_store(5'd12, 5'd26);
        run_store(5'd13, 5'd27);

        // second load offered under busy is dropped, v1 keeps its value
        next_delay   = 6;
        ref_regs[14] = mem[8];
        issue_insn(vmem_insn(7'h07, 2'b00, 5'd8, 5'd14));
        issue_insn(vmem_insn(7'h07, 2'b00, 5'd31, 5'd1));
        wait_not_busy();
        run_store(5'd1, 5'd24);

        // v5 must survive all three
        try_illegal(opivv_insn(6'h00, 1'b0, 5'd2, 5'd3, 5'd5), "masked vadd");
        try_illegal({1'b0, 11'h0c0, 5'd1, 3'b111, 5'd5, 7'h57}, "vsetvli");
        try_illegal(vmem_insn(7'h07, 2'b10, 5'd0, 5'd5), "strided load");
        run_store(5'd5, 5'd25);

        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: src/rvv_proc_main.sv
`timescale 1ns/1ns

module rvv_proc_main #(
    parameter int VLEN    = 64,
    parameter int NUM_VEC = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            insn_valid,
    input  logic [31:0]     insn,
    input  logic            mem_rvalid,
    input  logic [VLEN-1:0] mem_rdata,
    output logic            mem_rd,
    output logic            mem_we,
    output logic [4:0]      mem_addr,
    output logic [VLEN-1:0] mem_wdata,
    output logic            busy,
    output logic            illegal
);
    import rvv_pkg::*;

    localparam int ADDR_W = $clog2(NUM_VEC);

    // read side
    logic              rd_en_a;
    logic              rd_en_b;
    logic [ADDR_W-1:0] rd_addr_a;
    logic [ADDR_W-1:0] rd_addr_b;
    logic [VLEN-1:0]   rd_data_a;
    logic [VLEN-1:0]   rd_data_b;

    // execute stage
    logic              alu_start;
    logic              ld_start;
    logic              st_start;
    alu_op_t           alu_op;
    logic [ADDR_W-1:0] dest;
    logic [4:0]        mem_word;
    logic              alu_gnt;
    logic              lsu_gnt;

    // two requesters, one merged port
    vrf_if #(.VLEN(VLEN), .NUM_VEC(NUM_VEC)) alu_wr ();
    vrf_if #(.VLEN(VLEN), .NUM_VEC(NUM_VEC)) lsu_wr ();
    vrf_if #(.VLEN(VLEN), .NUM_VEC(NUM_VEC)) vrf_wr ();

    insn_decoder #(.NUM_VEC(NUM_VEC)) insn_decoder_i (
        .clk       (clk),
        .rst       (rst),
        .insn_valid(insn_valid),
        .insn      (insn),
        .busy      (busy),
        .rd_en_a   (rd_en_a),
        .rd_en_b   (rd_en_b),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .alu_start (alu_start),
        .ld_start  (ld_start),
        .st_start  (st_start),
        .alu_op    (alu_op),
        .dest      (dest),
        .mem_word  (mem_word),
        .illegal   (illegal)
    );

    vec_regfile #(.VLEN(VLEN), .NUM_VEC(NUM_VEC)) vec_regfile_i (
        .clk      (clk),
        .rst      (rst),
        .rd_en_a  (rd_en_a),
        .rd_en_b  (rd_en_b),
        .rd_addr_a(rd_addr_a),
        .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a),
        .rd_data_b(rd_data_b),
        .wr       (vrf_wr.storage)
    );

    vrf_write_arbiter vrf_write_arbiter_i (
        .clk    (clk),
        .rst    (rst),
        .alu_req(alu_wr.arbiter_side),
        .lsu_req(lsu_wr.arbiter_side),
        .vrf    (vrf_wr.requester),
        .alu_gnt(alu_gnt),
        .lsu_gnt(lsu_gnt)
    );

    vec_alu #(.VLEN(VLEN), .NUM_VEC(NUM_VEC)) vec_alu_i (
        .clk      (clk),
        .rst      (rst),
        .alu_start(alu_start),
        .alu_op   (alu_op),
        .dest     (dest),
        .rd_data_a(rd_data_a),
        .rd_data_b(rd_data_b),
        .gnt      (alu_gnt),
        .wr       (alu_wr.requester)
    );

    vec_lsu #(.VLEN(VLEN), .NUM_VEC(NUM_VEC)) vec_lsu_i (
        .clk       (clk),
        .rst       (rst),
        .ld_start  (ld_start),
        .st_start  (st_start),
        .dest      (dest),
        .mem_word  (mem_word),
        .rd_data_b (rd_data_b),
        .mem_rvalid(mem_rvalid),
        .mem_rdata (mem_rdata),
        .gnt       (lsu_gnt),
        .mem_rd    (mem_rd),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .busy      (busy),
        .wr        (lsu_wr.requester)
    );

endmodule

// File: src/vec_lsu.sv
`timescale 1ns/1ns

module vec_lsu #(
    parameter int VLEN    = 64,
    parameter int NUM_VEC = 32
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ld_start,
    input  logic                       st_start,
    input  logic [$clog2(NUM_VEC)-1:0] dest,
    input  logic [4:0]                 mem_word,
    input  logic [VLEN-1:0]            rd_data_b,
    input  logic                       mem_rvalid,
    input  logic [VLEN-1:0]            mem_rdata,
    input  logic                       gnt,
    output logic                       mem_rd,
    output logic                       mem_we,
    output logic [4:0]                 mem_addr,
    output logic [VLEN-1:0]            mem_wdata,
    output logic                       busy,
    vrf_if.requester                   wr
);
    // load sent, data not back yet
    logic                       ld_out;
    logic [$clog2(NUM_VEC)-1:0] ld_dest;
    logic [4:0]                 st_addr;

    // read request goes out straight from the decode strobe
    assign mem_rd   = ld_start;
    // store address once data is ready, else load word
    assign mem_addr = mem_we ? st_addr : mem_word;
    // covers request, wait and pending write
    assign busy     = ld_start || ld_out || wr.we;
    assign wr.be    = '1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ld_out <= 1'b0;
            mem_we <= 1'b0;
            wr.we  <= 1'b0;
        end else begin
            // one-cycle store strobe
            mem_we <= st_start;
            if (ld_start) begin
                ld_out <= 1'b1;
            end else if (mem_rvalid) begin
                ld_out <= 1'b0;
            end
            // returned data waits here for the port
            if (mem_rvalid) begin
                wr.we <= 1'b1;
            end else if (gnt) begin
                wr.we <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_start) begin
            ld_dest <= dest;
        end
        if (st_start) begin
            st_addr   <= mem_word;
            // vs3 as read at decode
            mem_wdata <= rd_data_b;
        end
        if (mem_rvalid) begin
            wr.addr  <= ld_dest;
            wr.wdata <= mem_rdata;
        end
    end

    a_rvalid_expected: assert property (@(posedge clk) disable iff (!rst)
        mem_rvalid |-> ld_out)
        else $error("memory response without outstanding load");

    // shared address bus, issuer must not put a load right behind a store
    a_no_rd_we_overlap: assert property (@(posedge clk) disable iff (!rst)
        !(mem_rd && mem_we))
        else $error("load request collides with store strobe");

endmodule

// File: src/vec_alu.sv
`timescale 1ns/1ns

module vec_alu #(
    parameter int VLEN    = 64,
    parameter int NUM_VEC = 32
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       alu_start,
    input  rvv_pkg::alu_op_t           alu_op,
    input  logic [$clog2(NUM_VEC)-1:0] dest,
    input  logic [VLEN-1:0]            rd_data_a,
    input  logic [VLEN-1:0]            rd_data_b,
    input  logic                       gnt,
    vrf_if.requester                   wr
);
    import rvv_pkg::*;

    localparam int LANES = VLEN / 8;

    logic [VLEN-1:0] result;

    // a = vs1, b = vs2; each lane wraps on its own
    always_comb begin
        logic [7:0] va;
        logic [7:0] vb;
        result = '0;
        for (int l = 0; l < LANES; l++) begin
            va = rd_data_a[8*l +: 8];
            vb = rd_data_b[8*l +: 8];
            case (alu_op)
                ADD:     result[8*l +: 8] = vb + va;
                SUB:     result[8*l +: 8] = vb - va;
                AND:     result[8*l +: 8] = vb & va;
                OR:      result[8*l +: 8] = vb | va;
                XOR:     result[8*l +: 8] = vb ^ va;
                default: result[8*l +: 8] = va;
            endcase
        end
    end

    // whole register written
    assign wr.be = '1;

    // request held until the grant edge
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr.we <= 1'b0;
        end else if (alu_start) begin
            wr.we <= 1'b1;
        end else if (gnt) begin
            wr.we <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            wr.addr  <= dest;
            wr.wdata <= result;
        end
    end

endmodule

// File: src/vrf_write_arbiter.sv
`timescale 1ns/1ns

module vrf_write_arbiter (
    input  logic         clk,
    input  logic         rst,
    vrf_if.arbiter_side  alu_req,
    vrf_if.arbiter_side  lsu_req,
    vrf_if.requester     vrf,
    output logic         alu_gnt,
    output logic         lsu_gnt
);
    // alu first, lsu takes the leftover cycles
    assign alu_gnt = alu_req.we;
    assign lsu_gnt = lsu_req.we && !alu_req.we;

    // forward the winner
    always_comb begin
        if (alu_req.we) begin
            vrf.we    = 1'b1;
            vrf.addr  = alu_req.addr;
            vrf.wdata = alu_req.wdata;
            vrf.be    = alu_req.be;
        end else begin
            vrf.we    = lsu_req.we;
            vrf.addr  = lsu_req.addr;
            vrf.wdata = lsu_req.wdata;
            vrf.be    = lsu_req.be;
        end
    end

    a_gnt_excl: assert property (@(posedge clk) disable iff (!rst)
        !(alu_gnt && lsu_gnt))
        else $error("both write grants high");

    // alu holds the port for one cycle per op, so a load only waits briefly
    a_lsu_wait: assert property (@(posedge clk) disable iff (!rst)
        lsu_req.we |-> ##[0:2] lsu_gnt)
        else $error("load write starved");

endmodule

// File: src/vec_regfile.sv
`timescale 1ns/1ns

module vec_regfile #(
    parameter int VLEN    = 64,
    parameter int NUM_VEC = 32
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rd_en_a,
    input  logic                       rd_en_b,
    input  logic [$clog2(NUM_VEC)-1:0] rd_addr_a,
    input  logic [$clog2(NUM_VEC)-1:0] rd_addr_b,
    output logic [VLEN-1:0]            rd_data_a,
    output logic [VLEN-1:0]            rd_data_b,
    vrf_if.storage                     wr
);
    localparam int NBYTES = VLEN / 8;

    logic [VLEN-1:0] regs [NUM_VEC];

    // byte-enabled write
    always_ff @(posedge clk) begin
        for (int i = 0; i < NBYTES; i++) begin
            if (wr.we && wr.be[i]) begin
                regs[wr.addr][8*i +: 8] <= wr.wdata[8*i +: 8];
            end
        end
    end

    // registered reads, same-cycle write not visible
    always_ff @(posedge clk) begin
        if (rd_en_a) begin
            rd_data_a <= regs[rd_addr_a];
        end
        if (rd_en_b) begin
            rd_data_b <= regs[rd_addr_b];
        end
    end

    // arbiter output must be clean when writing
    a_wr_addr_known: assert property (@(posedge clk) disable iff (!rst)
        wr.we |-> !$isunknown(wr.addr))
        else $error("register write with unknown address");

endmodule

// File: src/insn_decoder.sv
`timescale 1ns/1ns

module insn_decoder #(
    parameter int NUM_VEC = 32
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       insn_valid,
    input  rvv_pkg::rvv_insn_t         insn,
    input  logic                       busy,
    output logic                       rd_en_a,
    output logic                       rd_en_b,
    output logic [$clog2(NUM_VEC)-1:0] rd_addr_a,
    output logic [$clog2(NUM_VEC)-1:0] rd_addr_b,
    output logic                       alu_start,
    output logic                       ld_start,
    output logic                       st_start,
    output rvv_pkg::alu_op_t           alu_op,
    output logic [$clog2(NUM_VEC)-1:0] dest,
    output logic [4:0]                 mem_word,
    output logic                       illegal
);
    import rvv_pkg::*;

    localparam int ADDR_W = $clog2(NUM_VEC);

    logic    accept;
    logic    op_known;
    logic    mem_ok;
    logic    is_alu;
    logic    is_ld;
    logic    is_st;
    alu_op_t op_next;

    // anything arriving under busy is dropped
    assign accept = insn_valid && !busy;

    always_comb begin
        op_next  = ADD;
        op_known = 1'b1;
        case (insn.alu.funct6)
            F6_VADD: op_next = ADD;
            F6_VSUB: op_next = SUB;
            F6_VAND: op_next = AND;
            F6_VOR:  op_next = OR;
            F6_VXOR: op_next = XOR;
            F6_VMV:  op_next = MOV;
            default: op_known = 1'b0;
        endcase
    end

    // unmasked OPIVV only
    assign is_alu = (insn.alu.opcode == OPC_OPV) && (insn.alu.funct3 == OPIVV)
                    && insn.alu.vm && op_known;

    // unit stride, e64, single field, unmasked
    assign mem_ok = (insn.mem.width == WIDTH_E64) && (insn.mem.mop == 2'b00)
                    && !insn.mem.mew && (insn.mem.nf == 3'd0) && insn.mem.vm
                    && (insn.mem.lumop == 5'd0);
    assign is_ld  = (insn.mem.opcode == OPC_LOADFP) && mem_ok;
    assign is_st  = (insn.mem.opcode == OPC_STOREFP) && mem_ok;

    // read ports sampled by the regfile at the decode edge
    assign rd_en_a   = accept && is_alu;
    assign rd_en_b   = accept && (is_alu || is_st);
    assign rd_addr_a = ADDR_W'(insn.alu.vs1);
    // store data comes out of port b
    assign rd_addr_b = is_st ? ADDR_W'(insn.mem.vd) : ADDR_W'(insn.alu.vs2);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            alu_start <= 1'b0;
            ld_start  <= 1'b0;
            st_start  <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            alu_start <= accept && is_alu;
            ld_start  <= accept && is_ld;
            st_start  <= accept && is_st;
            illegal   <= accept && !(is_alu || is_ld || is_st);
        end
    end

    // execute-stage fields, qualified by the strobes
    always_ff @(posedge clk) begin
        if (accept) begin
            alu_op   <= op_next;
            // vd sits in the same bits in both layouts
            dest     <= ADDR_W'(insn.alu.vd);
            mem_word <= insn.mem.rs1;
        end
    end

    a_one_start: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({alu_start, ld_start, st_start}))
        else $error("more than one start strobe");

endmodule

// File: src/vrf_if.sv
`timescale 1ns/1ns

interface vrf_if #(
    parameter int VLEN    = 64,
    parameter int NUM_VEC = 32
);
    // one write port of the register file
    logic                       we;
    logic [$clog2(NUM_VEC)-1:0] addr;
    logic [VLEN-1:0]            wdata;
    // one bit per byte lane
    logic [VLEN/8-1:0]          be;

    modport requester    (output we, addr, wdata, be);
    modport arbiter_side (input we, addr, wdata, be);
    modport storage      (input we, addr, wdata, be);

endinterface

// File: src/rvv_pkg.sv
package rvv_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OPV     = 7'h57;
    localparam logic [6:0] OPC_LOADFP  = 7'h07;
    localparam logic [6:0] OPC_STOREFP = 7'h27;

    // funct3 for vector-vector integer ops
    localparam logic [2:0] OPIVV = 3'd0;

    // funct6 codes, OPIVV group
    localparam logic [5:0] F6_VADD = 6'h00;
    localparam logic [5:0] F6_VSUB = 6'h02;
    localparam logic [5:0] F6_VAND = 6'h09;
    localparam logic [5:0] F6_VOR  = 6'h0A;
    localparam logic [5:0] F6_VXOR = 6'h0B;
    localparam logic [5:0] F6_VMV  = 6'h17;

    // memory width field for 64-bit elements
    localparam logic [2:0] WIDTH_E64 = 3'd7;

    // arithmetic layout, msb first
    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } valu_fmt_t;

    // load/store layout, vd doubles as vs3 for stores
    typedef struct packed {
        logic [2:0] nf;
        logic       mew;
        logic [1:0] mop;
        logic       vm;
        logic [4:0] lumop;
        logic [4:0] rs1;
        logic [2:0] width;
        logic [4:0] vd;
        logic [6:0] opcode;
    } vmem_fmt_t;

    typedef union packed {
        valu_fmt_t alu;
        vmem_fmt_t mem;
    } rvv_insn_t;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, MOV} alu_op_t;

endpackage
